//--- source/core_cfg_pkg.sv
package core_cfg_pkg;

   // Operand width and bit position counter
   localparam int XLEN  = 32;
   localparam int CNT_W = 5;

   typedef logic [XLEN-1:0]  word_t;
   typedef logic [4:0]       reg_addr_t;
   typedef logic [CNT_W-1:0] bit_cnt_t;

   // Serial write port towards the register file
   typedef struct packed {
      logic      wen;
      reg_addr_t wreg;
      logic      wdata;
   } rf_wr_t;

endpackage

//--- source/rv_isa_pkg.sv
package rv_isa_pkg;

   // Major opcodes handled by the unit
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

   // funct3 codes, shared by register and immediate forms
   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLTU
   } alu_op_e;

   // Decoded controls, held for the whole instruction
   typedef struct packed {
      alu_op_e                 op;
      logic                    use_imm;
      logic                    two_pass;
      logic                    legal;
      core_cfg_pkg::reg_addr_t rd;
      core_cfg_pkg::reg_addr_t rs1;
      core_cfg_pkg::reg_addr_t rs2;
   } dec_ctrl_t;

endpackage

//--- source/instr_decode.sv
`timescale 1ns/100ps

module instr_decode (
   input  logic                  clk,
   input  logic                  i_rst_n,
   input  logic                  i_accept,
   input  core_cfg_pkg::word_t   i_instr,
   input  logic                  i_cnt_en,
   output rv_isa_pkg::dec_ctrl_t o_ctrl,
   output logic                  o_imm_bit
);

   logic [6:0]            opcode;
   logic [2:0]            funct3;
   logic [6:0]            funct7;
   logic                  is_op;
   logic                  is_op_imm;
   logic                  f3_ok;
   logic                  f7_ok;
   rv_isa_pkg::dec_ctrl_t dec;
   logic [11:0]           imm_q;

   assign opcode    = i_instr[6:0];
   assign funct3    = i_instr[14:12];
   assign funct7    = i_instr[31:25];
   assign is_op     = (opcode == rv_isa_pkg::OPC_OP);
   assign is_op_imm = (opcode == rv_isa_pkg::OPC_OP_IMM);

   // Shift codes 001 and 101 fall out as illegal
   always_comb begin
      case (funct3)
         rv_isa_pkg::F3_ADD,
         rv_isa_pkg::F3_SLT,
         rv_isa_pkg::F3_SLTU,
         rv_isa_pkg::F3_XOR,
         rv_isa_pkg::F3_OR,
         rv_isa_pkg::F3_AND: f3_ok = 1'b1;
         default:            f3_ok = 1'b0;
      endcase
   end

   // Only SUB may carry the alternate funct7
   assign f7_ok = (funct7 == 7'h00) ||
                  ((funct7 == 7'h20) && (funct3 == rv_isa_pkg::F3_ADD));

   always_comb begin
      dec = '0;
      case (funct3)
         rv_isa_pkg::F3_ADD:  dec.op = (is_op && funct7[5]) ? rv_isa_pkg::ALU_SUB
                                                            : rv_isa_pkg::ALU_ADD;
         rv_isa_pkg::F3_SLT:  dec.op = rv_isa_pkg::ALU_SLT;
         rv_isa_pkg::F3_SLTU: dec.op = rv_isa_pkg::ALU_SLTU;
         rv_isa_pkg::F3_XOR:  dec.op = rv_isa_pkg::ALU_XOR;
         rv_isa_pkg::F3_OR:   dec.op = rv_isa_pkg::ALU_OR;
         rv_isa_pkg::F3_AND:  dec.op = rv_isa_pkg::ALU_AND;
         default:             dec.op = rv_isa_pkg::ALU_ADD;
      endcase
      dec.use_imm  = is_op_imm;
      dec.two_pass = (dec.op == rv_isa_pkg::ALU_SLT) || (dec.op == rv_isa_pkg::ALU_SLTU);
      dec.legal    = (is_op && f3_ok && f7_ok) || (is_op_imm && f3_ok);
      dec.rd       = i_instr[11:7];
      dec.rs1      = i_instr[19:15];
      dec.rs2      = i_instr[24:20];
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_ctrl <= '0;
      end else if (i_accept) begin
         o_ctrl <= dec;
      end
   end

   // Arithmetic right shift, so the sign bit repeats after bit 11
   always_ff @(posedge clk) begin
      if (i_accept) begin
         imm_q <= i_instr[31:20];
      end else if (i_cnt_en) begin
         imm_q <= {imm_q[11], imm_q[11:1]};
      end
   end

   assign o_imm_bit = imm_q[0];

endmodule

//--- source/seq_state.sv
`timescale 1ns/100ps

module seq_state (
   input  logic                    clk,
   input  logic                    i_rst_n,
   input  logic                    i_instr_valid,
   input  logic                    i_rf_ready,
   input  rv_isa_pkg::dec_ctrl_t   i_ctrl,
   output logic                    o_accept,
   output logic                    o_busy,
   output logic                    o_done,
   output logic                    o_illegal,
   output logic                    o_rf_rreq,
   output logic                    o_cnt_en,
   output logic                    o_cnt0,
   output logic                    o_cmp_pass,
   output logic                    o_write_pass,
   output logic                    o_wen,
   output core_cfg_pkg::reg_addr_t o_wreg
);

   typedef enum logic [2:0] {
      IDLE,
      DECODE,
      WAIT_RF,
      PASS1,
      PASS2,
      FINISH
   } phase_e;

   phase_e                 state;
   phase_e                 state_nxt;
   core_cfg_pkg::bit_cnt_t cnt;
   logic                   cnt_last;
   logic                   rd_nonzero;

   assign o_busy   = (state == DECODE) || (state == WAIT_RF) ||
                     (state == PASS1) || (state == PASS2);
   assign o_accept = i_instr_valid && !o_busy;

   assign cnt_last = (cnt == core_cfg_pkg::bit_cnt_t'(core_cfg_pkg::XLEN - 1));

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE:    if (o_accept) state_nxt = DECODE;
         DECODE:  state_nxt = i_ctrl.legal ? WAIT_RF : FINISH;
         WAIT_RF: if (i_rf_ready) state_nxt = PASS1;
         PASS1: begin
            if (cnt_last) begin
               state_nxt = i_ctrl.two_pass ? PASS2 : FINISH;
            end
         end
         PASS2:   if (cnt_last) state_nxt = FINISH;
         FINISH:  state_nxt = o_accept ? DECODE : IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Wraps to zero at the end of every pass
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cnt <= '0;
      end else if (o_cnt_en) begin
         cnt <= cnt + 1'b1;
      end
   end

   assign o_cnt_en     = (state == PASS1) || (state == PASS2);
   assign o_cnt0       = o_cnt_en && (cnt == '0);
   assign o_cmp_pass   = (state == PASS1) && i_ctrl.two_pass;
   assign o_write_pass = (state == PASS2);

   assign o_rf_rreq = (state == DECODE) && i_ctrl.legal;
   assign o_done    = (state == FINISH);
   assign o_illegal = o_done && !i_ctrl.legal;

   // x0 is never written
   assign rd_nonzero = (i_ctrl.rd != '0);
   assign o_wen      = rd_nonzero && (o_write_pass || ((state == PASS1) && !i_ctrl.two_pass));
   assign o_wreg     = i_ctrl.rd;

endmodule

//--- source/serial_alu.sv
`timescale 1ns/100ps

module serial_alu (
   input  logic                  clk,
   input  logic                  i_rst_n,
   input  rv_isa_pkg::dec_ctrl_t i_ctrl,
   input  logic                  i_cnt_en,
   input  logic                  i_cnt0,
   input  logic                  i_cmp_pass,
   input  logic                  i_write_pass,
   input  logic                  i_rs1,
   input  logic                  i_rs2,
   input  logic                  i_imm_bit,
   output logic                  o_rd
);

   logic op_b;
   logic sub;
   logic b_eff;
   logic carry_in;
   logic carry_q;
   logic carry_out;
   logic sum;
   logic lt_now;
   logic cmp_q;
   logic alu_res;

   assign op_b = i_ctrl.use_imm ? i_imm_bit : i_rs2;

   // Compares are done as rs1 - op_b
   assign sub = (i_ctrl.op == rv_isa_pkg::ALU_SUB) ||
                (i_ctrl.op == rv_isa_pkg::ALU_SLT) ||
                (i_ctrl.op == rv_isa_pkg::ALU_SLTU);

   assign b_eff     = op_b ^ sub;
   assign carry_in  = i_cnt0 ? sub : carry_q;
   assign sum       = i_rs1 ^ b_eff ^ carry_in;
   assign carry_out = (i_rs1 & b_eff) | (carry_in & (i_rs1 ^ b_eff));

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
      end else if (i_cnt_en) begin
         carry_q <= carry_out;
      end
   end

   // Treats the current bit as the MSB and is final after bit 31
   assign lt_now = (i_ctrl.op == rv_isa_pkg::ALU_SLT) ? ((i_rs1 ^ op_b) ? i_rs1 : sum)
                                                      : ~carry_out;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cmp_q <= 1'b0;
      end else if (i_cnt_en && i_cmp_pass) begin
         cmp_q <= lt_now;
      end
   end

   always_comb begin
      case (i_ctrl.op)
         rv_isa_pkg::ALU_AND: alu_res = i_rs1 & op_b;
         rv_isa_pkg::ALU_OR:  alu_res = i_rs1 | op_b;
         rv_isa_pkg::ALU_XOR: alu_res = i_rs1 ^ op_b;
         default:             alu_res = sum;
      endcase
   end

   // Write pass puts the flag on bit 0 only
   assign o_rd = i_write_pass ? (i_cnt0 & cmp_q) : alu_res;

endmodule

//--- source/serial_alu_top.sv
`timescale 1ns/100ps

module serial_alu_top (
   input  logic                      clk,
   input  logic                      i_rst_n,
   input  logic                      i_instr_valid,
   input  core_cfg_pkg::word_t       i_instr,
   input  logic                      i_rf_ready,
   input  logic                      i_rdata0,
   input  logic                      i_rdata1,
   output logic                      o_busy,
   output logic                      o_done,
   output logic                      o_illegal,
   output logic                      o_rf_rreq,
   output core_cfg_pkg::reg_addr_t   o_rreg0,
   output core_cfg_pkg::reg_addr_t   o_rreg1,
   output core_cfg_pkg::rf_wr_t      o_rf_wr
);

   rv_isa_pkg::dec_ctrl_t   ctrl;
   logic                    accept;
   logic                    cnt_en;
   logic                    cnt0;
   logic                    cmp_pass;
   logic                    write_pass;
   logic                    imm_bit;
   logic                    rd_bit;
   logic                    wen;
   core_cfg_pkg::reg_addr_t wreg;

   instr_decode u_instr_decode (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_accept  (accept),
      .i_instr   (i_instr),
      .i_cnt_en  (cnt_en),
      .o_ctrl    (ctrl),
      .o_imm_bit (imm_bit)
   );

   seq_state u_seq_state (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_instr_valid (i_instr_valid),
      .i_rf_ready    (i_rf_ready),
      .i_ctrl        (ctrl),
      .o_accept      (accept),
      .o_busy        (o_busy),
      .o_done        (o_done),
      .o_illegal     (o_illegal),
      .o_rf_rreq     (o_rf_rreq),
      .o_cnt_en      (cnt_en),
      .o_cnt0        (cnt0),
      .o_cmp_pass    (cmp_pass),
      .o_write_pass  (write_pass),
      .o_wen         (wen),
      .o_wreg        (wreg)
   );

   serial_alu u_serial_alu (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_ctrl       (ctrl),
      .i_cnt_en     (cnt_en),
      .i_cnt0       (cnt0),
      .i_cmp_pass   (cmp_pass),
      .i_write_pass (write_pass),
      .i_rs1        (i_rdata0),
      .i_rs2        (i_rdata1),
      .i_imm_bit    (imm_bit),
      .o_rd         (rd_bit)
   );

   // Read addresses come straight from the latched instruction
   assign o_rreg0 = ctrl.rs1;
   assign o_rreg1 = ctrl.rs2;

   assign o_rf_wr = '{wen: wen, wreg: wreg, wdata: rd_bit};

endmodule

//--- tb/serial_alu_chk.sv
`timescale 1ns/100ps

module serial_alu_chk (
   input logic                    clk,
   input logic                    i_rst_n,
   input logic                    i_wen,
   input core_cfg_pkg::reg_addr_t i_wreg,
   input logic                    i_rf_rreq,
   input logic                    i_done
);

   // x0 stays read-only
   a_no_x0_write: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      i_wen |-> (i_wreg != '0)
   ) else $error("write enable raised with x0 as target");

   // Request and write belong to different phases
   a_rreq_wen_apart: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      !(i_rf_rreq && i_wen)
   ) else $error("read request and write enable high in the same cycle");

   a_done_pulse: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      i_done |=> !i_done
   ) else $error("done held high for more than one cycle");

endmodule

//--- tb/tb_serial_alu.sv
`timescale 1ns/100ps

module tb_serial_alu;

   localparam int CLK_PERIOD  = 40;
   localparam int MAX_INSTR   = 300;
   localparam int INSTR_CYC   = 80;
   localparam int WATCHDOG_NS = MAX_INSTR * INSTR_CYC * CLK_PERIOD;
   localparam int DONE_LIMIT  = 120;

   logic                      clk = 1'b0;
   logic                      i_rst_n;
   logic                      i_instr_valid;
   core_cfg_pkg::word_t       i_instr;
   logic                      i_rf_ready;
   logic                      i_rdata0;
   logic                      i_rdata1;
   logic                      o_busy;
   logic                      o_done;
   logic                      o_illegal;
   logic                      o_rf_rreq;
   core_cfg_pkg::reg_addr_t   o_rreg0;
   core_cfg_pkg::reg_addr_t   o_rreg1;
   core_cfg_pkg::rf_wr_t      o_rf_wr;

   // Register file as seen by the DUT, and the reference copy
   core_cfg_pkg::word_t       rf [32];
   core_cfg_pkg::word_t       model [32];
   core_cfg_pkg::bit_cnt_t    wr_pos;
   int unsigned               wen_total;
   int unsigned               rreq_total;
   int unsigned               done_total;
   int unsigned               instr_count;
   int unsigned               ready_delay;

   always #(CLK_PERIOD / 2) clk = ~clk;

   serial_alu_top u_serial_alu_top (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_instr_valid (i_instr_valid),
      .i_instr       (i_instr),
      .i_rf_ready    (i_rf_ready),
      .i_rdata0      (i_rdata0),
      .i_rdata1      (i_rdata1),
      .o_busy        (o_busy),
      .o_done        (o_done),
      .o_illegal     (o_illegal),
      .o_rf_rreq     (o_rf_rreq),
      .o_rreg0       (o_rreg0),
      .o_rreg1       (o_rreg1),
      .o_rf_wr       (o_rf_wr)
   );

   bind seq_state serial_alu_chk u_chk (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_wen     (o_wen),
      .i_wreg    (o_wreg),
      .i_rf_rreq (o_rf_rreq),
      .i_done    (o_done)
   );

   task automatic report_mismatch(input string name, input string what,
                                  input logic [31:0] expected, input logic [31:0] actual);
      $display("FAIL %s %s: expected %h actual %h", name, what, expected, actual);
      $display("Test failures found");
      $fatal(1, "stopped at first mismatch");
   endtask

   task automatic report_error(input string msg);
      $display("ERROR %s", msg);
      $display("Test failures found");
      $fatal(1, "stopped on error");
   endtask

   function automatic core_cfg_pkg::reg_addr_t pick_reg(input int unsigned lo,
                                                        input int unsigned hi);
      return core_cfg_pkg::reg_addr_t'($urandom_range(hi, lo));
   endfunction

   function automatic core_cfg_pkg::word_t encode_reg_op(input logic [6:0] f7,
                                                         input logic [4:0] rs2,
                                                         input logic [4:0] rs1,
                                                         input logic [2:0] f3,
                                                         input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
   endfunction

   function automatic core_cfg_pkg::word_t encode_imm_op(input logic [11:0] imm,
                                                         input logic [4:0] rs1,
                                                         input logic [2:0] f3,
                                                         input logic [4:0] rd);
      return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
   endfunction

   // 0..6 ADD SUB AND OR XOR SLT SLTU, 7..12 ADDI ANDI ORI XORI SLTI SLTIU
   function automatic core_cfg_pkg::word_t make_alu(input int unsigned sel,
                                                    input logic [4:0] rd,
                                                    input logic [4:0] rs1,
                                                    input logic [4:0] rs2,
                                                    input logic [11:0] imm);
      case (sel)
         0:       return encode_reg_op(7'h00, rs2, rs1, 3'b000, rd);
         1:       return encode_reg_op(7'h20, rs2, rs1, 3'b000, rd);
         2:       return encode_reg_op(7'h00, rs2, rs1, 3'b111, rd);
         3:       return encode_reg_op(7'h00, rs2, rs1, 3'b110, rd);
         4:       return encode_reg_op(7'h00, rs2, rs1, 3'b100, rd);
         5:       return encode_reg_op(7'h00, rs2, rs1, 3'b010, rd);
         6:       return encode_reg_op(7'h00, rs2, rs1, 3'b011, rd);
         7:       return encode_imm_op(imm, rs1, 3'b000, rd);
         8:       return encode_imm_op(imm, rs1, 3'b111, rd);
         9:       return encode_imm_op(imm, rs1, 3'b110, rd);
         10:      return encode_imm_op(imm, rs1, 3'b100, rd);
         11:      return encode_imm_op(imm, rs1, 3'b010, rd);
         default: return encode_imm_op(imm, rs1, 3'b011, rd);
      endcase
   endfunction

   function automatic bit instr_legal(input core_cfg_pkg::word_t instr);
      logic [2:0] f3;
      logic [6:0] f7;
      bit         f3_ok;
      f3    = instr[14:12];
      f7    = instr[31:25];
      f3_ok = (f3 != 3'b001) && (f3 != 3'b101);
      if (instr[6:0] == rv_isa_pkg::OPC_OP_IMM) begin
         return f3_ok;
      end
      if (instr[6:0] == rv_isa_pkg::OPC_OP) begin
         return f3_ok && ((f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'b000)));
      end
      return 1'b0;
   endfunction

   function automatic core_cfg_pkg::word_t ref_result(input core_cfg_pkg::word_t instr,
                                                      input core_cfg_pkg::word_t a,
                                                      input core_cfg_pkg::word_t rs2_val);
      core_cfg_pkg::word_t b;
      b = (instr[6:0] == rv_isa_pkg::OPC_OP_IMM) ? {{20{instr[31]}}, instr[31:20]} : rs2_val;
      case (instr[14:12])
         3'b000:  return ((instr[6:0] == rv_isa_pkg::OPC_OP) && instr[30]) ? a - b : a + b;
         3'b010:  return {31'd0, $signed(a) < $signed(b)};
         3'b011:  return {31'd0, a < b};
         3'b100:  return a ^ b;
         3'b110:  return a | b;
         3'b111:  return a & b;
         default: return '0;
      endcase
   endfunction

   // Write collection and event counters
   always @(posedge clk) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 32; i++) begin
            rf[i] <= '0;
         end
         wr_pos     <= '0;
         wen_total  <= 0;
         rreq_total <= 0;
         done_total <= 0;
      end else begin
         if (o_rf_rreq) begin
            rreq_total <= rreq_total + 1;
         end
         if (o_done) begin
            done_total <= done_total + 1;
         end
         if (o_rf_wr.wen) begin
            rf[o_rf_wr.wreg][wr_pos] <= o_rf_wr.wdata;
            wr_pos    <= wr_pos + 1'b1;
            wen_total <= wen_total + 1;
         end else begin
            wr_pos <= '0;
         end
      end
   end

   // Serial read side drives bits LSB first after the ready pulse
   initial begin : rf_model
      core_cfg_pkg::word_t a;
      core_cfg_pkg::word_t b;
      i_rf_ready = 1'b0;
      i_rdata0   = 1'b0;
      i_rdata1   = 1'b0;
      forever begin
         @(negedge clk);
         if (i_rst_n && o_rf_rreq) begin
            repeat (ready_delay) @(negedge clk);
            a          = rf[o_rreg0];
            b          = rf[o_rreg1];
            i_rf_ready = 1'b1;
            for (int k = 0; k < 32; k++) begin
               @(negedge clk);
               i_rf_ready = 1'b0;
               i_rdata0   = a[k];
               i_rdata1   = b[k];
            end
            @(negedge clk);
            i_rdata0 = 1'b0;
            i_rdata1 = 1'b0;
         end
      end
   end

   task automatic check_rf(input string name);
      for (int i = 0; i < 32; i++) begin
         assert (rf[i] === model[i])
            else report_mismatch(name, $sformatf("x%0d", i), model[i], rf[i]);
      end
   endtask

   task automatic run_instr(input core_cfg_pkg::word_t instr, input string name);
      bit          legal;
      bit          writes;
      bit          done_seen;
      int unsigned rreq0;
      int unsigned wen0;
      int unsigned cycles;
      int unsigned exp_rreq;
      int unsigned exp_wen;
      int unsigned exp_cycles;
      legal         = instr_legal(instr);
      writes        = legal && (instr[11:7] != 5'd0);
      exp_rreq      = legal ? 1 : 0;
      exp_wen       = writes ? 32 : 0;
      rreq0         = rreq_total;
      wen0          = wen_total;
      ready_delay   = $urandom_range(4, 1);
      // Decode, ready wait, one or two passes of 32 bits, then done
      if (!legal) begin
         exp_cycles = 2;
      end else if (instr[14:13] == 2'b01) begin
         exp_cycles = 66 + ready_delay;
      end else begin
         exp_cycles = 34 + ready_delay;
      end
      i_instr       = instr;
      i_instr_valid = 1'b1;
      cycles        = 0;
      done_seen     = 1'b0;
      while (!done_seen) begin
         @(negedge clk);
         cycles++;
         if (cycles == 1) begin
            assert (o_busy === 1'b1)
               else report_error($sformatf("%s: o_busy low after acceptance", name));
         end
         if (o_done) begin
            done_seen     = 1'b1;
            i_instr_valid = 1'b0;
         end else if (cycles > DONE_LIMIT) begin
            report_error($sformatf("%s: no o_done within %0d cycles", name, DONE_LIMIT));
         end else begin
            // Strobes while busy must be ignored
            i_instr_valid = ($urandom_range(3, 0) == 0);
            i_instr       = $urandom();
         end
      end
      assert (o_illegal === !legal)
         else report_mismatch(name, "o_illegal", 32'(!legal), 32'(o_illegal));
      assert (o_busy === 1'b0)
         else report_error($sformatf("%s: o_busy still high with o_done", name));
      assert (cycles == exp_cycles)
         else report_mismatch(name, "done cycle", exp_cycles, cycles);
      if (writes) begin
         model[instr[11:7]] = ref_result(instr, model[instr[19:15]], model[instr[24:20]]);
      end
      @(negedge clk);
      instr_count++;
      assert (done_total == instr_count)
         else report_mismatch(name, "done count", instr_count, done_total);
      assert (rreq_total - rreq0 == exp_rreq)
         else report_mismatch(name, "rreq pulses", exp_rreq, rreq_total - rreq0);
      assert (wen_total - wen0 == exp_wen)
         else report_mismatch(name, "wen cycles", exp_wen, wen_total - wen0);
      check_rf(name);
   endtask

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("ERROR watchdog expired before the test sequence finished");
      $display("Test failures found");
      $fatal(1, "watchdog timeout");
   end

   initial begin : main
      core_cfg_pkg::reg_addr_t edge_regs [4];
      core_cfg_pkg::word_t     word;
      logic [11:0]             imm;
      logic [11:0]             imm_edges [4];
      int unsigned             sel;
      void'($urandom(23295));
      i_rst_n       = 1'b0;
      i_instr_valid = 1'b0;
      i_instr       = '0;
      instr_count   = 0;
      ready_delay   = 1;
      edge_regs     = '{5'd0, 5'd28, 5'd29, 5'd30};
      imm_edges     = '{12'h000, 12'hfff, 12'h800, 12'h7ff};
      for (int i = 0; i < 32; i++) begin
         model[i] = '0;
      end
      repeat (5) @(negedge clk);
      i_rst_n = 1'b1;
      @(negedge clk);

      // Load every register through ADDI from x0
      for (int r = 1; r < 32; r++) begin
         imm = 12'($urandom());
         run_instr(make_alu(7, 5'(r), 5'd0, 5'd0, imm), "addi_load");
      end

      for (int n = 0; n < 100; n++) begin
         sel = $urandom_range(8, 0);
         if (sel > 4) begin
            sel = sel + 2;
         end
         imm = 12'($urandom());
         run_instr(make_alu(sel, pick_reg(1, 31), pick_reg(0, 31), pick_reg(0, 31), imm),
                   "alu_random");
      end

      // x28 = 0x80000000 by doubling -2048, then all ones, max positive, a copy
      run_instr(make_alu(7, 5'd28, 5'd0, 5'd0, 12'h800), "edge_setup");
      repeat (20) run_instr(make_alu(0, 5'd28, 5'd28, 5'd28, 12'h000), "edge_setup");
      run_instr(make_alu(7, 5'd29, 5'd0, 5'd0, 12'hfff), "edge_setup");
      run_instr(make_alu(7, 5'd30, 5'd28, 5'd0, 12'hfff), "edge_setup");
      run_instr(make_alu(7, 5'd27, 5'd28, 5'd0, 12'h000), "edge_setup");

      for (int i = 0; i < 4; i++) begin
         for (int j = 0; j < 4; j++) begin
            run_instr(make_alu(5, pick_reg(1, 26), edge_regs[i], edge_regs[j], '0), "slt_edge");
            run_instr(make_alu(6, pick_reg(1, 26), edge_regs[i], edge_regs[j], '0), "sltu_edge");
         end
      end
      run_instr(make_alu(5, 5'd1, 5'd27, 5'd28, '0), "slt_equal");
      run_instr(make_alu(6, 5'd2, 5'd27, 5'd28, '0), "sltu_equal");

      for (int n = 0; n < 8; n++) begin
         sel = 11 + $urandom_range(1, 0);
         run_instr(make_alu(sel, pick_reg(1, 26), edge_regs[$urandom_range(3, 0)], 5'd0,
                            imm_edges[$urandom_range(3, 0)]), "slti_edge");
      end

      for (int n = 0; n < 40; n++) begin
         sel = $urandom_range(3, 0);
         sel = (sel < 2) ? sel + 5 : sel + 9;
         imm = 12'($urandom());
         run_instr(make_alu(sel, pick_reg(1, 26), pick_reg(0, 31), pick_reg(0, 31), imm),
                   "cmp_random");
      end

      for (int n = 0; n < 10; n++) begin
         sel = $urandom_range(12, 0);
         imm = 12'($urandom());
         run_instr(make_alu(sel, 5'd0, pick_reg(0, 31), pick_reg(0, 31), imm), "x0_write");
      end

      for (int n = 0; n < 20; n++) begin
         word = $urandom();
         case (n % 4)
            0: begin
               if ((word[6:0] == rv_isa_pkg::OPC_OP) ||
                   (word[6:0] == rv_isa_pkg::OPC_OP_IMM)) begin
                  word[6] = ~word[6];
               end
            end
            1: begin
               word[6:0]   = rv_isa_pkg::OPC_OP;
               word[31:25] = 7'h00;
               word[14:12] = word[14] ? 3'b101 : 3'b001;
            end
            2: begin
               word[6:0]   = rv_isa_pkg::OPC_OP_IMM;
               word[14:12] = word[14] ? 3'b101 : 3'b001;
            end
            default: begin
               word[6:0]   = rv_isa_pkg::OPC_OP;
               word[31:25] = 7'h01;
            end
         endcase
         run_instr(word, "illegal");
      end

      $display("All tests passed!");
      $finish;
   end

endmodule

//--- compile.f
source/core_cfg_pkg.sv
source/rv_isa_pkg.sv
source/instr_decode.sv
source/seq_state.sv
source/serial_alu.sv
source/serial_alu_top.sv
tb/serial_alu_chk.sv
tb/tb_serial_alu.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_serial_alu, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_serial_alu \
		-f compile.f -Mdir obj_dir -o vsim
	-./obj_dir/vsim > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
